//--- bench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                          // 10 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

//--- bench/tb_fetch.sv
`timescale 1ns/1ns

module tb_fetch;

    localparam logic [31:0] RESET_PC     = 32'h1eceb000;
    localparam int          QUEUE_DEPTH  = 16;
    localparam int          RESET_CYCLES = 8;

    logic                    clk;
    logic                    rst;
    logic [31:0]             bmem_addr;
    logic                    bmem_read;
    logic                    bmem_ready;
    logic [63:0]             bmem_rdata;
    logic                    bmem_rvalid;
    logic                    inst_valid;
    fetch_pkg::fetch_entry_t fetched;
    logic                    dequeue;

    logic [31:0] rng_state;
    logic [31:0] exp_pc;                                // model pc of the next popped entry
    logic [31:0] next_line;                             // line the next read must ask for
    logic [31:0] burst_addr;
    logic [7:0]  slot_mask;
    logic        ready_en;
    logic        long_gaps;
    logic        popped;
    logic        timed_out;
    int          beats_left, beat_idx, hold_left, pop_count, read_count;
    int          err_count, tests_run, tests_failed, test_errs;
    int          deq_mode;                              // 0 random, 1 held low, 2 held high

    tb_clock #(.RESET_CYCLES(RESET_CYCLES)) u_clock (.clk(clk), .rst(rst));

    fetch_top #(
        .RESET_PC    (RESET_PC),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) DUT (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_o   (bmem_addr),
        .bmem_read_o   (bmem_read),
        .bmem_ready_i  (bmem_ready),
        .bmem_rdata_i  (bmem_rdata),
        .bmem_rvalid_i (bmem_rvalid),
        .inst_valid_o  (inst_valid),
        .inst_o        (fetched),
        .dequeue_i     (dequeue)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        err_count++;
    endtask

    task automatic note_failure(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        err_count++;
    endtask

    task automatic report_timeout(input string msg);
        $display("Timeout at %0t ns: %s", $time, msg);
        timed_out = 1'b1;
        err_count++;
    endtask

    task automatic start_test();
        test_errs = err_count;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (err_count != test_errs) tests_failed++;
        $display("test %0d %s: %0d errors", tests_run, name, err_count - test_errs);
    endtask

    // sample outputs after the edge, then drive inputs for the next one
    task automatic run_cycle();
        logic        go;
        logic [31:0] beat_addr;
        @(posedge clk);
        #1;
        popped = 1'b0;
        if (bmem_read === 1'b1) begin
            read_count++;
            if (beats_left != 0) note_failure("read issued while a burst was still returning");
            if (bmem_addr !== next_line) report_mismatch("bmem_addr_o", bmem_addr, next_line);
            burst_addr = bmem_addr;
            next_line  = next_line + 32'd32;
            beats_left = 4;
            beat_idx   = 0;
        end
        go          = long_gaps ? ((next_rand() & 32'h7) == 0) : ((next_rand() & 32'h3) != 0);
        bmem_rvalid = 1'b0;
        if (beats_left != 0 && go) begin
            beat_addr   = burst_addr + 32'(8 * beat_idx);  // lowest address first
            bmem_rvalid = 1'b1;
            bmem_rdata  = {xorshift32(beat_addr + 32'd4), xorshift32(beat_addr)};
            beat_idx++;
            beats_left--;
        end
        bmem_ready = ready_en && ((next_rand() & 32'h7) != 0);
        case (deq_mode)
            1: dequeue = 1'b0;
            2: dequeue = 1'b1;
            default: begin
                if (hold_left > 0) begin
                    hold_left--;
                    dequeue = 1'b0;
                end else begin
                    if ((next_rand() & 32'h1f) == 0) hold_left = 10 + int'(next_rand() % 32'd30);
                    dequeue = (next_rand() % 32'd3) != 0;
                end
            end
        endcase
        if (dequeue && inst_valid === 1'b1) begin   // head leaves at the next edge
            popped = 1'b1;
            pop_count++;
            if (fetched.pc !== exp_pc) report_mismatch("inst_o.pc", fetched.pc, exp_pc);
            if (fetched.inst !== xorshift32(exp_pc)) begin
                report_mismatch("inst_o.inst", fetched.inst, xorshift32(exp_pc));
            end
            if (fetched.pc === exp_pc && fetched.inst === xorshift32(exp_pc)) begin
                slot_mask[exp_pc[4:2]] = 1'b1;
            end
            exp_pc = exp_pc + 32'd4;
        end
    endtask

    task automatic run_until_pops(input int target, input int limit);
        int cycles;
        cycles = 0;
        while (pop_count < target && cycles < limit) begin
            run_cycle();
            cycles++;
        end
        if (pop_count < target) report_timeout("entries stopped arriving at the consumer");
    endtask

    // returns once no burst, pop or refill has happened for a few cycles
    task automatic wait_idle(input string what);
        int quiet;
        int cycles;
        quiet  = 0;
        cycles = 0;
        while (quiet < 6 && cycles < 2000) begin
            run_cycle();
            cycles++;
            quiet = (beats_left != 0 || popped) ? 0 : quiet + 1;
        end
        if (quiet < 6) report_timeout(what);
    endtask

    task automatic run_tests();
        int          cycles;
        int          avail;
        logic [31:0] lines;

        start_test();
        for (cycles = 0; cycles <= RESET_CYCLES; cycles++) begin
            run_cycle();
            if (bmem_read !== 1'b0) report_mismatch("bmem_read_o", 32'(bmem_read), 32'd0);
            if (inst_valid !== 1'b0) report_mismatch("inst_valid_o", 32'(inst_valid), 32'd0);
        end
        if (rst !== 1'b0) note_failure("reset still asserted after its cycles");
        end_test("reset state");

        start_test();
        ready_en = 1'b1;
        deq_mode = 0;
        run_until_pops(200, 40000);
        if (timed_out) return;
        end_test("in-order stream of 200 instructions");

        start_test();
        deq_mode = 1;
        repeat (60) run_cycle();
        ready_en = 1'b0;                                // freeze fetch, then count what is held
        wait_idle("fetch did not settle while the consumer was stalled");
        if (timed_out) return;
        deq_mode = 2;
        avail    = 0;
        do begin
            run_cycle();
            avail += int'(popped);
        end while (popped && avail <= QUEUE_DEPTH + 4);
        if (avail > QUEUE_DEPTH) note_failure("more entries held than the queue depth");
        if (avail == 0) note_failure("no entries held while the consumer was stalled");
        ready_en = 1'b1;
        deq_mode = 0;
        run_until_pops(pop_count + 40, 20000);
        if (timed_out) return;
        end_test("consumer stall and release");

        start_test();
        long_gaps = 1'b1;
        slot_mask = '0;
        run_until_pops(pop_count + 48, 40000);
        if (timed_out) return;
        long_gaps = 1'b0;
        if (slot_mask != 8'hff) note_failure("a word slot of a line never returned its word");
        end_test("long gaps between beats");

        start_test();
        ready_en = 1'b0;
        deq_mode = 2;
        wait_idle("queue did not drain");
        if (timed_out) return;
        lines = ((exp_pc - 32'd4) >> 5) - (RESET_PC >> 5) + 32'd1;
        if (32'(read_count) != lines) begin
            report_mismatch("bmem_read_o pulse count", 32'(read_count), lines);
        end
        end_test("one read per line");
    endtask

    initial begin
        rng_state    = 32'h88d2;
        bmem_ready   = 1'b0;
        bmem_rdata   = '0;
        bmem_rvalid  = 1'b0;
        dequeue      = 1'b0;
        exp_pc       = RESET_PC;
        next_line    = {RESET_PC[31:5], 5'b0};
        slot_mask    = '0;
        ready_en     = 1'b0;
        long_gaps    = 1'b0;
        timed_out    = 1'b0;
        deq_mode     = 1;
        beats_left   = 0;
        beat_idx     = 0;
        hold_left    = 0;
        pop_count    = 0;
        read_count   = 0;
        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_errs    = 0;

        run_tests();

        $display("tests %0d, failed %0d, errors %0d, entries checked %0d",
                 tests_run, tests_failed, err_count, pop_count);
        if (err_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
src/fetch_pkg.sv
src/fetch_pc.sv
src/icache.sv
src/cacheline_adapter.sv
src/inst_queue.sv
src/fetch_top.sv
bench/tb_clock.sv
bench/tb_fetch.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_fetch -f build.f -Mdir obj_dir

output=$(./obj_dir/Vtb_fetch)
echo "$output"

if echo "$output" | grep -q "Simulation PASSED"; then
    exit 0
fi
exit 1

//--- src/cacheline_adapter.sv
`timescale 1ns/1ns

module cacheline_adapter (
    input  logic              clk,
    input  logic              rst,
    input  fetch_pkg::beat_t  bmem_rdata_i,
    input  logic              bmem_rvalid_i,
    output fetch_pkg::line_t  line_o,
    output logic              line_valid_o
);

    localparam int CNT_W = $clog2(fetch_pkg::BEATS_PER_LINE);

    logic [CNT_W-1:0] beat_cnt;                         // slot of the next beat
    fetch_pkg::line_t line_q;
    logic             last_beat;

    assign last_beat = (beat_cnt == CNT_W'(fetch_pkg::BEATS_PER_LINE - 1));
    assign line_o    = line_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt     <= '0;
            line_valid_o <= 1'b0;
        end else begin
            line_valid_o <= 1'b0;
            if (bmem_rvalid_i) begin
                beat_cnt <= beat_cnt + CNT_W'(1);       // wraps after the last beat
                if (last_beat) begin
                    line_valid_o <= 1'b1;
                end
            end
        end
    end

    // lowest address beat lands in the lowest slot
    always_ff @(posedge clk) begin
        if (bmem_rvalid_i) begin
            line_q[beat_cnt*fetch_pkg::BEAT_W +: fetch_pkg::BEAT_W] <= bmem_rdata_i;
        end
    end

endmodule

//--- src/fetch_pc.sv
`timescale 1ns/1ns

module fetch_pc #(
    parameter logic [fetch_pkg::XLEN-1:0] RESET_PC = 32'h1eceb000
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   queue_full_i,
    input  logic                   bmem_ready_i,
    input  logic                   resp_i,
    output logic                   req_o,
    output fetch_pkg::fetch_addr_t req_addr_o
);

    logic [fetch_pkg::XLEN-1:0] pc;
    logic                       outstanding;            // request in flight

    // one request at a time, held off while the queue is full
    assign req_o          = !outstanding && !queue_full_i && bmem_ready_i;
    assign req_addr_o.raw = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= RESET_PC;
            outstanding <= 1'b0;
        end else if (resp_i) begin
            pc          <= pc + fetch_pkg::XLEN'(4);    // next sequential word
            outstanding <= 1'b0;
        end else if (req_o) begin
            outstanding <= 1'b1;
        end
    end

    // the cache only answers a pending request
    a_resp_has_req: assert property (
        @(posedge clk) disable iff (rst)
        resp_i |-> outstanding
    );

endmodule

//--- src/fetch_pkg.sv
package fetch_pkg;

    localparam int XLEN           = 32;
    localparam int BEAT_W         = 64;
    localparam int LINE_W         = 256;
    localparam int BEATS_PER_LINE = 4;
    localparam int WORDS_PER_LINE = 8;
    localparam int OFFSET_W       = 5;                          // byte offset within a line

    // 8 sets, tied to the cache's set count
    localparam int INDEX_W        = 3;
    localparam int TAG_W          = XLEN - INDEX_W - OFFSET_W;

    typedef logic [LINE_W-1:0] line_t;
    typedef logic [BEAT_W-1:0] beat_t;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } addr_fields_t;

    // one fetch address word, seen as a byte address or as cache fields
    typedef union packed {
        logic [XLEN-1:0] raw;
        addr_fields_t    fields;
    } fetch_addr_t;

    typedef struct packed {
        logic [XLEN-1:0] inst;
        logic [XLEN-1:0] pc;
    } fetch_entry_t;

endpackage

//--- src/fetch_top.sv
`timescale 1ns/1ns

module fetch_top #(
    parameter logic [fetch_pkg::XLEN-1:0] RESET_PC    = 32'h1eceb000,
    parameter int                         QUEUE_DEPTH = 16
) (
    input  logic                       clk,
    input  logic                       rst,

    output logic [fetch_pkg::XLEN-1:0] bmem_addr_o,
    output logic                       bmem_read_o,
    input  logic                       bmem_ready_i,
    input  fetch_pkg::beat_t           bmem_rdata_i,
    input  logic                       bmem_rvalid_i,

    output logic                       inst_valid_o,
    output fetch_pkg::fetch_entry_t    inst_o,
    input  logic                       dequeue_i
);

    logic                       req;
    fetch_pkg::fetch_addr_t     req_addr;           // also the pc of the pending fetch
    logic                       resp;
    logic [fetch_pkg::XLEN-1:0] rdata;
    logic                       line_valid;
    fetch_pkg::line_t           line;
    logic                       queue_full;

    fetch_pc #(
        .RESET_PC     (RESET_PC)
    ) u_fetch_pc (
        .clk          (clk),
        .rst          (rst),
        .queue_full_i (queue_full),
        .bmem_ready_i (bmem_ready_i),
        .resp_i       (resp),
        .req_o        (req),
        .req_addr_o   (req_addr)
    );

    icache u_icache (
        .clk          (clk),
        .rst          (rst),
        .req_i        (req),
        .req_addr_i   (req_addr),
        .resp_o       (resp),
        .rdata_o      (rdata),
        .bmem_addr_o  (bmem_addr_o),
        .bmem_read_o  (bmem_read_o),
        .line_valid_i (line_valid),
        .line_i       (line)
    );

    cacheline_adapter u_adapter (
        .clk           (clk),
        .rst           (rst),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .line_o        (line),
        .line_valid_o  (line_valid)
    );

    inst_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_inst_queue (
        .clk         (clk),
        .rst         (rst),
        .enqueue_i   (resp),
        .inst_i      (rdata),
        .pc_i        (req_addr),
        .dequeue_i   (dequeue_i),
        .head_o      (inst_o),
        .valid_o     (inst_valid_o),
        .full_o      (queue_full)
    );

endmodule

//--- src/icache.sv
`timescale 1ns/1ns

module icache (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req_i,
    input  fetch_pkg::fetch_addr_t     req_addr_i,
    output logic                       resp_o,
    output logic [fetch_pkg::XLEN-1:0] rdata_o,
    output logic [fetch_pkg::XLEN-1:0] bmem_addr_o,
    output logic                       bmem_read_o,
    input  logic                       line_valid_i,
    input  fetch_pkg::line_t           line_i
);

    localparam int SETS       = 1 << fetch_pkg::INDEX_W;
    localparam int WORD_SEL_W = $clog2(fetch_pkg::WORDS_PER_LINE);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_RESP
    } state_t;

    state_t                        state;
    fetch_pkg::fetch_addr_t        addr_q;              // address of the current request
    logic [SETS-1:0]               valid_arr;
    logic [fetch_pkg::TAG_W-1:0]   tag_arr [SETS];
    fetch_pkg::line_t              line_arr [SETS];
    fetch_pkg::line_t              line_sel;
    logic [WORD_SEL_W-1:0]         word_sel;
    logic                          hit;

    assign hit = valid_arr[req_addr_i.fields.index]
              && (tag_arr[req_addr_i.fields.index] == req_addr_i.fields.tag);

    assign line_sel = line_arr[addr_q.fields.index];
    assign word_sel = addr_q.fields.offset[fetch_pkg::OFFSET_W-1 -: WORD_SEL_W];
    assign rdata_o  = line_sel[word_sel*fetch_pkg::XLEN +: fetch_pkg::XLEN];
    assign resp_o   = (state == ST_RESP);

    // line aligned miss address
    assign bmem_addr_o = {addr_q.raw[fetch_pkg::XLEN-1:fetch_pkg::OFFSET_W],
                          {fetch_pkg::OFFSET_W{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            bmem_read_o <= 1'b0;
            valid_arr   <= '0;
        end else begin
            bmem_read_o <= 1'b0;                        // single cycle pulse
            case (state)
                ST_IDLE: begin
                    if (req_i) begin
                        if (hit) begin
                            state <= ST_RESP;
                        end else begin
                            bmem_read_o <= 1'b1;
                            state       <= ST_WAIT;
                        end
                    end
                end
                ST_WAIT: begin
                    if (line_valid_i) begin
                        valid_arr[addr_q.fields.index] <= 1'b1;
                        state                          <= ST_RESP;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req_i) begin
            addr_q <= req_addr_i;
        end
        if (state == ST_WAIT && line_valid_i) begin
            line_arr[addr_q.fields.index] <= line_i;    // fill the missed set
            tag_arr[addr_q.fields.index]  <= addr_q.fields.tag;
        end
    end

    // the adapter only returns a line that this cache asked for
    a_line_in_wait: assert property (
        @(posedge clk) disable iff (rst)
        line_valid_i |-> (state == ST_WAIT)
    );

endmodule

//--- src/inst_queue.sv
`timescale 1ns/1ns

module inst_queue #(
    parameter int QUEUE_DEPTH = 16
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       enqueue_i,
    input  logic [fetch_pkg::XLEN-1:0] inst_i,
    input  fetch_pkg::fetch_addr_t     pc_i,
    input  logic                       dequeue_i,
    output fetch_pkg::fetch_entry_t    head_o,
    output logic                       valid_o,
    output logic                       full_o
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    fetch_pkg::fetch_entry_t mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    logic [CNT_W-1:0]        count;
    logic                    do_deq;

    assign do_deq  = dequeue_i && valid_o;              // pop on empty is dropped
    assign valid_o = (count != '0);
    assign full_o  = (count == CNT_W'(QUEUE_DEPTH));
    assign head_o  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (enqueue_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (do_deq) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
            count <= count + CNT_W'(enqueue_i) - CNT_W'(do_deq);
        end
    end

    always_ff @(posedge clk) begin
        if (enqueue_i) begin
            mem[wr_ptr] <= '{inst: inst_i, pc: pc_i.raw};
        end
    end

    // fetch stops issuing before the queue can overflow
    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        enqueue_i |-> !full_o
    );

endmodule
